//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int REG_COUNT     = 32;
    localparam int REG_IDX_WIDTH = 5;
    // sign-extended to DATA_WIDTH before use
    localparam int IMM_WIDTH     = 16;

    // only OP_ADDI takes the immediate as its second source
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI
    } opcode_t;

endpackage

`default_nettype wire

//--- verilog/sb_pkg.sv
`default_nettype none

package sb_pkg;

    // UNIT_NONE doubles as "no pending producer"
    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU0,
        UNIT_ALU1
    } unit_t;

    // lifetime of one window slot
    typedef enum logic [2:0] {
        ENTRY_FREE,
        ENTRY_WAITING,
        ENTRY_DISPATCHED,
        ENTRY_ISSUED,
        ENTRY_DONE
    } entry_state_t;

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                              clk,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] raddr0,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] raddr1,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] raddr2,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] raddr3,
    output logic [isa_pkg::DATA_WIDTH-1:0]    rdata0,
    output logic [isa_pkg::DATA_WIDTH-1:0]    rdata1,
    output logic [isa_pkg::DATA_WIDTH-1:0]    rdata2,
    output logic [isa_pkg::DATA_WIDTH-1:0]    rdata3,
    input  logic                              we,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] waddr,
    input  logic [isa_pkg::DATA_WIDTH-1:0]    wdata
);

    logic [isa_pkg::DATA_WIDTH-1:0] regs [isa_pkg::REG_COUNT];

    // r0 is never written and always reads zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_status_table.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_table (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              set_valid,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] set_rd,
    input  sb_pkg::unit_t                     set_unit,
    input  logic                              retire_valid,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] retire_rd,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rd_query,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs1_query,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs2_query,
    output sb_pkg::unit_t                     rd_producer,
    output sb_pkg::unit_t                     rs1_producer,
    output sb_pkg::unit_t                     rs2_producer
);

    sb_pkg::unit_t producer [isa_pkg::REG_COUNT];

    // a register cleared by this cycle's retire already reads as free
    assign rd_producer  = (retire_valid && retire_rd == rd_query) ?
                          sb_pkg::UNIT_NONE : producer[rd_query];
    assign rs1_producer = (retire_valid && retire_rd == rs1_query) ?
                          sb_pkg::UNIT_NONE : producer[rs1_query];
    assign rs2_producer = (retire_valid && retire_rd == rs2_query) ?
                          sb_pkg::UNIT_NONE : producer[rs2_query];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < isa_pkg::REG_COUNT; i++) begin
                producer[i] <= sb_pkg::UNIT_NONE;
            end
        end else begin
            if (retire_valid) begin
                producer[retire_rd] <= sb_pkg::UNIT_NONE;
            end
            // written last so dispatch wins on the same register
            if (set_valid && set_rd != '0) begin
                producer[set_rd] <= set_unit;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_station.sv
`timescale 1ns/1ps
`default_nettype none

module alu_station #(
    parameter int            WINDOW_DEPTH = 16,
    parameter sb_pkg::unit_t UNIT_ID      = sb_pkg::UNIT_ALU0,
    localparam int           TAG_WIDTH    = $clog2(WINDOW_DEPTH)
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              dispatch_valid,
    input  isa_pkg::opcode_t                  op,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rd,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs1,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] rs2,
    input  logic [isa_pkg::IMM_WIDTH-1:0]     imm,
    input  logic [TAG_WIDTH-1:0]              tag,
    input  sb_pkg::unit_t                     rs1_producer,
    input  sb_pkg::unit_t                     rs2_producer,
    input  logic                              retire_valid,
    input  sb_pkg::unit_t                     retire_unit,
    input  logic [TAG_WIDTH-1:0]              retire_tag,
    input  logic [isa_pkg::DATA_WIDTH-1:0]    rs1_data,
    input  logic [isa_pkg::DATA_WIDTH-1:0]    rs2_data,
    output logic                              busy,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0] rs1_addr,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0] rs2_addr,
    output logic                              done,
    output logic [TAG_WIDTH-1:0]              done_tag,
    output logic [isa_pkg::DATA_WIDTH-1:0]    done_data
);

    localparam int EXT_WIDTH = isa_pkg::DATA_WIDTH - isa_pkg::IMM_WIDTH;

    isa_pkg::opcode_t                  op_q;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] rd_q;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] rs1_q;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] rs2_q;
    logic [isa_pkg::IMM_WIDTH-1:0]     imm_q;
    logic [TAG_WIDTH-1:0]              tag_q;
    logic [isa_pkg::DATA_WIDTH-1:0]    result_q;
    logic [isa_pkg::DATA_WIDTH-1:0]    opnd2;
    logic [isa_pkg::DATA_WIDTH-1:0]    alu_out;
    sb_pkg::unit_t                     t1;
    sb_pkg::unit_t                     t2;
    logic                              issued;
    logic                              issue;
    logic                              release_entry;

    assign issue = busy && !issued && t1 == sb_pkg::UNIT_NONE && t2 == sb_pkg::UNIT_NONE;
    assign release_entry = retire_valid && retire_unit == UNIT_ID && retire_tag == tag_q;

    assign rs1_addr  = rs1_q;
    assign rs2_addr  = rs2_q;
    assign done_tag  = tag_q;
    assign done_data = result_q;

    assign opnd2 = (op_q == isa_pkg::OP_ADDI) ? {{EXT_WIDTH{imm_q[isa_pkg::IMM_WIDTH-1]}}, imm_q}
                                              : rs2_data;

    always_comb begin
        case (op_q)
            isa_pkg::OP_ADD,
            isa_pkg::OP_ADDI: alu_out = rs1_data + opnd2;
            isa_pkg::OP_SUB:  alu_out = rs1_data - opnd2;
            isa_pkg::OP_AND:  alu_out = rs1_data & opnd2;
            isa_pkg::OP_OR:   alu_out = rs1_data | opnd2;
            isa_pkg::OP_XOR:  alu_out = rs1_data ^ opnd2;
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy   <= 1'b0;
            issued <= 1'b0;
            done   <= 1'b0;
            t1     <= sb_pkg::UNIT_NONE;
            t2     <= sb_pkg::UNIT_NONE;
        end else begin
            done <= issue;
            if (dispatch_valid) begin
                busy   <= 1'b1;
                issued <= 1'b0;
                t1     <= rs1_producer;
                // immediate form has no second source to wait on
                t2     <= (op == isa_pkg::OP_ADDI) ? sb_pkg::UNIT_NONE : rs2_producer;
            end else begin
                if (release_entry) begin
                    busy <= 1'b0;
                end
                if (issue) begin
                    issued <= 1'b1;
                end
                if (retire_valid && t1 == retire_unit) begin
                    t1 <= sb_pkg::UNIT_NONE;
                end
                if (retire_valid && t2 == retire_unit) begin
                    t2 <= sb_pkg::UNIT_NONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            op_q  <= op;
            rd_q  <= rd;
            rs1_q <= rs1;
            rs2_q <= rs2;
            imm_q <= imm;
            tag_q <= tag;
        end
        // a write to r0 carries zero so the commit port matches the register file
        if (issue) begin
            result_q <= (rd_q == '0) ? '0 : alu_out;
        end
    end

endmodule

`default_nettype wire

//--- verilog/inst_window.sv
`timescale 1ns/1ps
`default_nettype none

module inst_window #(
    parameter int WINDOW_DEPTH = 16,
    localparam int TAG_WIDTH = $clog2(WINDOW_DEPTH)
) (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  logic                                      in_valid,
    output logic                                      in_ready,
    input  isa_pkg::opcode_t                          in_op,
    input  sb_pkg::unit_t                             in_unit,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0]         in_rd,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0]         in_rs1,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0]         in_rs2,
    input  logic [isa_pkg::IMM_WIDTH-1:0]             in_imm,
    input  logic [1:0]                                station_busy,
    input  sb_pkg::unit_t                             rd_producer,
    output logic [1:0]                                dispatch_valid,
    output isa_pkg::opcode_t                          dispatch_op,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0]         dispatch_rd,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0]         dispatch_rs1,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0]         dispatch_rs2,
    output logic [isa_pkg::IMM_WIDTH-1:0]             dispatch_imm,
    output logic [TAG_WIDTH-1:0]                      dispatch_tag,
    input  logic [1:0]                                done,
    input  logic [1:0][TAG_WIDTH-1:0]                 done_tag,
    input  logic [1:0][isa_pkg::DATA_WIDTH-1:0]       done_data,
    output logic                                      retire_valid,
    output sb_pkg::unit_t                             retire_unit,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0]         retire_rd,
    output logic [TAG_WIDTH-1:0]                      retire_tag,
    output logic [isa_pkg::DATA_WIDTH-1:0]            retire_data
);

    sb_pkg::entry_state_t                 state    [WINDOW_DEPTH];
    isa_pkg::opcode_t                     op_q     [WINDOW_DEPTH];
    sb_pkg::unit_t                        unit_q   [WINDOW_DEPTH];
    logic [isa_pkg::REG_IDX_WIDTH-1:0]    rd_q     [WINDOW_DEPTH];
    logic [isa_pkg::REG_IDX_WIDTH-1:0]    rs1_q    [WINDOW_DEPTH];
    logic [isa_pkg::REG_IDX_WIDTH-1:0]    rs2_q    [WINDOW_DEPTH];
    logic [isa_pkg::IMM_WIDTH-1:0]        imm_q    [WINDOW_DEPTH];
    logic [isa_pkg::DATA_WIDTH-1:0]       result_q [WINDOW_DEPTH];

    // extra msb on write and read pointers tells full from empty
    logic [TAG_WIDTH:0]   wptr;
    logic [TAG_WIDTH:0]   rptr;
    logic [TAG_WIDTH-1:0] dptr;
    logic [TAG_WIDTH-1:0] head;
    logic                 accept;
    logic                 unit_free;
    logic                 dispatch_ok;

    assign head     = rptr[TAG_WIDTH-1:0];
    assign in_ready = (wptr - rptr) != (TAG_WIDTH+1)'(WINDOW_DEPTH);
    assign accept   = in_valid && in_ready;

    always_comb begin
        case (unit_q[dptr])
            sb_pkg::UNIT_ALU0: unit_free = !station_busy[0];
            sb_pkg::UNIT_ALU1: unit_free = !station_busy[1];
            default:           unit_free = 1'b0;
        endcase
    end

    // in-order dispatch, held back on a busy station or a pending rd
    assign dispatch_ok = (state[dptr] == sb_pkg::ENTRY_WAITING) && unit_free
                         && (rd_producer == sb_pkg::UNIT_NONE);

    assign dispatch_valid[0] = dispatch_ok && (unit_q[dptr] == sb_pkg::UNIT_ALU0);
    assign dispatch_valid[1] = dispatch_ok && (unit_q[dptr] == sb_pkg::UNIT_ALU1);
    assign dispatch_op       = op_q[dptr];
    assign dispatch_rd       = rd_q[dptr];
    assign dispatch_rs1      = rs1_q[dptr];
    assign dispatch_rs2      = rs2_q[dptr];
    assign dispatch_imm      = imm_q[dptr];
    assign dispatch_tag      = dptr;

    assign retire_valid = state[head] == sb_pkg::ENTRY_DONE;
    assign retire_unit  = unit_q[head];
    assign retire_rd    = rd_q[head];
    assign retire_tag   = head;
    assign retire_data  = result_q[head];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr <= '0;
            rptr <= '0;
            dptr <= '0;
            for (int i = 0; i < WINDOW_DEPTH; i++) begin
                state[i] <= sb_pkg::ENTRY_FREE;
            end
        end else begin
            if (accept) begin
                state[wptr[TAG_WIDTH-1:0]] <= sb_pkg::ENTRY_WAITING;
                wptr <= wptr + 1'b1;
            end
            if (dispatch_ok) begin
                state[dptr] <= sb_pkg::ENTRY_DISPATCHED;
                dptr <= dptr + 1'b1;
            end
            for (int u = 0; u < 2; u++) begin
                if (done[u]) begin
                    state[done_tag[u]] <= sb_pkg::ENTRY_DONE;
                end
            end
            if (retire_valid) begin
                state[head] <= sb_pkg::ENTRY_FREE;
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q[wptr[TAG_WIDTH-1:0]]   <= in_op;
            unit_q[wptr[TAG_WIDTH-1:0]] <= in_unit;
            rd_q[wptr[TAG_WIDTH-1:0]]   <= in_rd;
            rs1_q[wptr[TAG_WIDTH-1:0]]  <= in_rs1;
            rs2_q[wptr[TAG_WIDTH-1:0]]  <= in_rs2;
            imm_q[wptr[TAG_WIDTH-1:0]]  <= in_imm;
        end
        for (int u = 0; u < 2; u++) begin
            if (done[u]) begin
                result_q[done_tag[u]] <= done_data[u];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/scoreboard_top.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_top #(
    parameter int WINDOW_DEPTH = 16,
    localparam int TAG_WIDTH = $clog2(WINDOW_DEPTH)
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  isa_pkg::opcode_t                  in_op,
    input  sb_pkg::unit_t                     in_unit,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] in_rd,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] in_rs1,
    input  logic [isa_pkg::REG_IDX_WIDTH-1:0] in_rs2,
    input  logic [isa_pkg::IMM_WIDTH-1:0]     in_imm,
    output logic                              commit_valid,
    output logic [TAG_WIDTH-1:0]              commit_tag,
    output logic [isa_pkg::REG_IDX_WIDTH-1:0] commit_rd,
    output logic [isa_pkg::DATA_WIDTH-1:0]    commit_data
);

    logic [1:0]                                station_busy;
    logic [1:0]                                dispatch_valid;
    isa_pkg::opcode_t                          dispatch_op;
    logic [isa_pkg::REG_IDX_WIDTH-1:0]         dispatch_rd;
    logic [isa_pkg::REG_IDX_WIDTH-1:0]         dispatch_rs1;
    logic [isa_pkg::REG_IDX_WIDTH-1:0]         dispatch_rs2;
    logic [isa_pkg::IMM_WIDTH-1:0]             dispatch_imm;
    logic [TAG_WIDTH-1:0]                      dispatch_tag;
    sb_pkg::unit_t                             dispatch_unit;
    sb_pkg::unit_t                             rd_producer;
    sb_pkg::unit_t                             rs1_producer;
    sb_pkg::unit_t                             rs2_producer;
    logic [1:0]                                done;
    logic [1:0][TAG_WIDTH-1:0]                 done_tag;
    logic [1:0][isa_pkg::DATA_WIDTH-1:0]       done_data;
    logic [1:0][isa_pkg::REG_IDX_WIDTH-1:0]    rs1_addr;
    logic [1:0][isa_pkg::REG_IDX_WIDTH-1:0]    rs2_addr;
    logic [1:0][isa_pkg::DATA_WIDTH-1:0]       rs1_data;
    logic [1:0][isa_pkg::DATA_WIDTH-1:0]       rs2_data;
    sb_pkg::unit_t                             retire_unit;

    // the commit port is the retire broadcast
    assign dispatch_unit = dispatch_valid[1] ? sb_pkg::UNIT_ALU1 : sb_pkg::UNIT_ALU0;

    inst_window #(.WINDOW_DEPTH(WINDOW_DEPTH)) u_window (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_op          (in_op),
        .in_unit        (in_unit),
        .in_rd          (in_rd),
        .in_rs1         (in_rs1),
        .in_rs2         (in_rs2),
        .in_imm         (in_imm),
        .station_busy   (station_busy),
        .rd_producer    (rd_producer),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .dispatch_tag   (dispatch_tag),
        .done           (done),
        .done_tag       (done_tag),
        .done_data      (done_data),
        .retire_valid   (commit_valid),
        .retire_unit    (retire_unit),
        .retire_rd      (commit_rd),
        .retire_tag     (commit_tag),
        .retire_data    (commit_data)
    );

    reg_status_table u_status (
        .clk          (clk),
        .resetn       (resetn),
        .set_valid    (|dispatch_valid),
        .set_rd       (dispatch_rd),
        .set_unit     (dispatch_unit),
        .retire_valid (commit_valid),
        .retire_rd    (commit_rd),
        .rd_query     (dispatch_rd),
        .rs1_query    (dispatch_rs1),
        .rs2_query    (dispatch_rs2),
        .rd_producer  (rd_producer),
        .rs1_producer (rs1_producer),
        .rs2_producer (rs2_producer)
    );

    for (genvar u = 0; u < 2; u++) begin : g_station
        alu_station #(
            .WINDOW_DEPTH (WINDOW_DEPTH),
            .UNIT_ID      (sb_pkg::unit_t'(u + 1))
        ) u_station (
            .clk            (clk),
            .resetn         (resetn),
            .dispatch_valid (dispatch_valid[u]),
            .op             (dispatch_op),
            .rd             (dispatch_rd),
            .rs1            (dispatch_rs1),
            .rs2            (dispatch_rs2),
            .imm            (dispatch_imm),
            .tag            (dispatch_tag),
            .rs1_producer   (rs1_producer),
            .rs2_producer   (rs2_producer),
            .retire_valid   (commit_valid),
            .retire_unit    (retire_unit),
            .retire_tag     (commit_tag),
            .rs1_data       (rs1_data[u]),
            .rs2_data       (rs2_data[u]),
            .busy           (station_busy[u]),
            .rs1_addr       (rs1_addr[u]),
            .rs2_addr       (rs2_addr[u]),
            .done           (done[u]),
            .done_tag       (done_tag[u]),
            .done_data      (done_data[u])
        );
    end

    regfile u_regfile (
        .clk    (clk),
        .raddr0 (rs1_addr[0]),
        .raddr1 (rs2_addr[0]),
        .raddr2 (rs1_addr[1]),
        .raddr3 (rs2_addr[1]),
        .rdata0 (rs1_data[0]),
        .rdata1 (rs2_data[0]),
        .rdata2 (rs1_data[1]),
        .rdata3 (rs2_data[1]),
        .we     (commit_valid),
        .waddr  (commit_rd),
        .wdata  (commit_data)
    );

endmodule

`default_nettype wire

//--- bench/scoreboard_sva.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_sva #(
    parameter int WINDOW_DEPTH = 16,
    localparam int TAG_WIDTH = $clog2(WINDOW_DEPTH)
) (
    input logic                              clk,
    input logic                              resetn,
    input logic                              in_ready,
    input logic                              commit_valid,
    input logic [TAG_WIDTH-1:0]              commit_tag,
    input logic [isa_pkg::REG_IDX_WIDTH-1:0] commit_rd,
    input logic [isa_pkg::DATA_WIDTH-1:0]    commit_data
);

    int unsigned          failures = 0;
    logic [TAG_WIDTH-1:0] next_tag;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            next_tag <= '0;
        end else if (commit_valid) begin
            next_tag <= commit_tag + 1'b1;
        end
    end

    // reset leaves the window empty and the commit port quiet
    reset_state: assert property (@(posedge clk) !resetn |=> in_ready && !commit_valid)
        else begin
            failures++;
            $error("in_ready low or commit_valid high after reset");
        end

    commit_tag_step: assert property (@(posedge clk) disable iff (!resetn)
        commit_valid |-> commit_tag == next_tag)
        else begin
            failures++;
            $error("commit_tag did not advance by one");
        end

    commit_known: assert property (@(posedge clk) disable iff (!resetn)
        commit_valid |-> !$isunknown({commit_rd, commit_data}))
        else begin
            failures++;
            $error("commit fields unknown during a commit");
        end

    // a full window only frees a slot through a commit
    full_release: assert property (@(posedge clk) disable iff (!resetn)
        !in_ready |=> in_ready == $past(commit_valid))
        else begin
            failures++;
            $error("full window changed occupancy without matching a commit");
        end

endmodule

bind scoreboard_top scoreboard_sva #(.WINDOW_DEPTH(WINDOW_DEPTH)) sva_inst (
    .clk          (clk),
    .resetn       (resetn),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_tag   (commit_tag),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
);

`default_nettype wire

//--- bench/scoreboard_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_tb;

    localparam int WINDOW_DEPTH    = 16;
    localparam int TAG_WIDTH       = $clog2(WINDOW_DEPTH);
    localparam int RANDOM_COUNT    = 300;
    localparam int BURST_LEN       = 6;
    localparam int CHAIN_LEN       = 40;
    localparam int INST_COUNT      = isa_pkg::REG_COUNT + RANDOM_COUNT
                                     + 2 * (BURST_LEN + 1) + CHAIN_LEN;
    // a fully serialized instruction takes about five cycles
    localparam int CYCLES_PER_INST = 10;
    localparam int TIMEOUT_NS      = (INST_COUNT * CYCLES_PER_INST + 50) * 10;

    logic                              clk = 1'b0;
    logic                              resetn;
    logic                              in_valid;
    logic                              in_ready;
    isa_pkg::opcode_t                  in_op;
    sb_pkg::unit_t                     in_unit;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] in_rd;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] in_rs1;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] in_rs2;
    logic [isa_pkg::IMM_WIDTH-1:0]     in_imm;
    logic                              commit_valid;
    logic [TAG_WIDTH-1:0]              commit_tag;
    logic [isa_pkg::REG_IDX_WIDTH-1:0] commit_rd;
    logic [isa_pkg::DATA_WIDTH-1:0]    commit_data;

    logic [15:0]                       lfsr = 16'd69;
    logic [isa_pkg::DATA_WIDTH-1:0]    ref_regs [isa_pkg::REG_COUNT];
    logic [isa_pkg::REG_IDX_WIDTH-1:0] exp_rd [$];
    logic [isa_pkg::DATA_WIDTH-1:0]    exp_data [$];
    int                                accepted = 0;
    int                                committed = 0;
    int                                errors = 0;
    int                                checks = 0;
    logic                              saw_full = 1'b0;

    scoreboard_top #(.WINDOW_DEPTH(WINDOW_DEPTH)) scoreboard_top_inst (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_unit      (in_unit),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, one shift per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [isa_pkg::REG_IDX_WIDTH-1:0] pick_reg(input int span_bits);
        logic [31:0] r;
        r = take_bits(span_bits);
        return r[isa_pkg::REG_IDX_WIDTH-1:0];
    endfunction

    function automatic logic [31:0] expected_result(input isa_pkg::opcode_t op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b,
                                                    input logic [15:0] imm);
        case (op)
            isa_pkg::OP_ADD:  return a + b;
            isa_pkg::OP_SUB:  return a - b;
            isa_pkg::OP_AND:  return a & b;
            isa_pkg::OP_OR:   return a | b;
            isa_pkg::OP_XOR:  return a ^ b;
            isa_pkg::OP_ADDI: return a + {{16{imm[15]}}, imm};
            default:          return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Fail %s: expected %h, actual %h", test, expected, actual);
    endtask

    // holds the instruction until the window takes it
    task automatic send(input isa_pkg::opcode_t op, input sb_pkg::unit_t unit,
                        input logic [isa_pkg::REG_IDX_WIDTH-1:0] rd,
                        input logic [isa_pkg::REG_IDX_WIDTH-1:0] rs1,
                        input logic [isa_pkg::REG_IDX_WIDTH-1:0] rs2,
                        input logic [isa_pkg::IMM_WIDTH-1:0] imm);
        @(negedge clk);
        in_valid = 1'b1;
        in_op    = op;
        in_unit  = unit;
        in_rd    = rd;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_imm   = imm;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // reference model and checks, on pre-edge values
    always @(posedge clk) begin : monitor
        int          occupancy;
        logic [31:0] v;
        if (resetn) begin
            occupancy = accepted - committed;
            assert (occupancy <= WINDOW_DEPTH) else begin
                errors++;
                $display("more than %0d instructions outstanding", WINDOW_DEPTH);
            end
            assert (in_ready == (occupancy != WINDOW_DEPTH))
                else report_mismatch("back_pressure in_ready",
                                     32'(occupancy != WINDOW_DEPTH), 32'(in_ready));
            if (!in_ready) begin
                saw_full = 1'b1;
            end
            if (commit_valid) begin
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("commit seen with no instruction outstanding");
                end else begin
                    checks += 3;
                    assert (commit_tag == committed[TAG_WIDTH-1:0])
                        else report_mismatch("commit_order tag",
                                             32'(committed[TAG_WIDTH-1:0]), 32'(commit_tag));
                    assert (commit_rd == exp_rd[0])
                        else report_mismatch("commit_order rd", 32'(exp_rd[0]), 32'(commit_rd));
                    assert (commit_data == exp_data[0])
                        else report_mismatch("result_value", exp_data[0], commit_data);
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                end
                committed++;
            end
            if (in_valid && in_ready) begin
                // r0 writes carry zero and leave r0 at zero
                v = (in_rd == '0) ? '0
                    : expected_result(in_op, ref_regs[in_rs1], ref_regs[in_rs2], in_imm);
                if (in_rd != '0) begin
                    ref_regs[in_rd] = v;
                end
                exp_rd.push_back(in_rd);
                exp_data.push_back(v);
                accepted++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns with %0d accepted and %0d committed",
                 TIMEOUT_NS, accepted, committed);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        isa_pkg::opcode_t                  op;
        sb_pkg::unit_t                     unit;
        logic [isa_pkg::REG_IDX_WIDTH-1:0] rd;
        logic [isa_pkg::REG_IDX_WIDTH-1:0] rs1;
        logic [isa_pkg::REG_IDX_WIDTH-1:0] rs2;
        logic [isa_pkg::REG_IDX_WIDTH-1:0] target;
        logic [31:0]                       r;
        int                                sva_failures;
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_op    = isa_pkg::OP_ADD;
        in_unit  = sb_pkg::UNIT_ALU0;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        for (int i = 0; i < isa_pkg::REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // load every register, r0 included, from r0
        for (int i = 0; i < isa_pkg::REG_COUNT; i++) begin
            r    = take_bits(16);
            unit = i[0] ? sb_pkg::UNIT_ALU1 : sb_pkg::UNIT_ALU0;
            send(isa_pkg::OP_ADDI, unit, i[4:0], '0, '0, r[15:0]);
        end

        // narrow register range so RAW and WAW hazards are frequent
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            r    = take_bits(3);
            op   = isa_pkg::opcode_t'(r[2:0] % 3'd6);
            r    = take_bits(1);
            unit = r[0] ? sb_pkg::UNIT_ALU1 : sb_pkg::UNIT_ALU0;
            rd   = pick_reg(3);
            rs1  = pick_reg(3);
            rs2  = pick_reg(3);
            r    = take_bits(16);
            send(op, unit, rd, rs1, rs2, r[15:0]);
        end

        // write bursts on one register, then a read of it
        for (int t = 0; t < 2; t++) begin
            target = (t == 0) ? 5'd0 : 5'd6;
            for (int k = 0; k < BURST_LEN; k++) begin
                r    = take_bits(16);
                unit = k[0] ? sb_pkg::UNIT_ALU1 : sb_pkg::UNIT_ALU0;
                send(isa_pkg::OP_ADDI, unit, target, target, '0, r[15:0]);
            end
            send(isa_pkg::OP_ADD, sb_pkg::UNIT_ALU1, 5'd7, target, target, '0);
        end

        // dependent chain on ALU0 outruns retire and fills the window
        for (int k = 0; k < CHAIN_LEN; k++) begin
            send(isa_pkg::OP_ADDI, sb_pkg::UNIT_ALU0, 5'd2, 5'd2, '0, 16'd1);
        end
        @(negedge clk);
        in_valid = 1'b0;

        while (exp_rd.size() != 0) begin
            @(negedge clk);
        end
        assert (saw_full) else begin
            errors++;
            $display("window never reached full occupancy");
        end
        @(negedge clk);
        sva_failures = scoreboard_top_inst.sva_inst.failures;
        $display("%0d checks, %0d errors, %0d assertion failures, %0d commits",
                 checks, errors, sva_failures, committed);
        if (errors == 0 && sva_failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/isa_pkg.sv
verilog/sb_pkg.sv
verilog/regfile.sv
verilog/reg_status_table.sv
verilog/alu_station.sv
verilog/inst_window.sv
verilog/scoreboard_top.sv
bench/scoreboard_sva.sv
bench/scoreboard_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= scoreboard_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= FAIL: see errors above

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
